// File: hw/pio_table_pkg.sv
/* table sizes, pio address fields, bus timer constants and the structs
   shared by the pio table datapath, access fsm and top level. */

package pio_table_pkg;

	// pio bus and table entry widths.
	localparam int PIO_NBITS      = 32;
	localparam int ENTRY_NBITS    = 50;
	// the odd dword carries what is left above the low dword.
	localparam int HI_NBITS       = ENTRY_NBITS - PIO_NBITS;
	// 1024 entries.
	localparam int DEPTH_NBITS    = 10;
	localparam int PIO_ADDR_NBITS = 16;

	// byte address layout, index sits above the dword half select.
	localparam int HALF_BIT = 2;
	localparam int IDX_LSB  = 3;

	// slow bus tick every TICK_DIV clocks.
	localparam int TICK_DIV       = 4;
	localparam int TICK_CNT_NBITS = $clog2(TICK_DIV);
	localparam logic [TICK_CNT_NBITS-1:0] TICK_LAST = TICK_CNT_NBITS'(TICK_DIV - 1);

	// index reg, ram read, output reg.
	localparam int APP_RD_LAT = 3;

	// one-cycle pio request from the bus master.
	typedef struct packed {
		logic [PIO_ADDR_NBITS-1:0] addr;
		logic [PIO_NBITS-1:0]      wdata;
		logic                      rd;
		logic                      wr;
		logic                      ms;
	} pio_req_t;

	// application lookup request.
	typedef struct packed {
		logic                   rd;
		logic [DEPTH_NBITS-1:0] addr;
	} app_rd_t;

	// application lookup response, fixed latency.
	typedef struct packed {
		logic                   ack;
		logic [ENTRY_NBITS-1:0] data;
	} app_rsp_t;

	// per-cycle strobes from the access fsm to the datapath.
	typedef struct packed {
		logic stage_lo;
		logic commit;
		logic rd_issue;
		logic capture;
		logic send_hi;
	} pio_ctl_t;

endpackage

// File: hw/ram_1r1w.sv
/* simple dual-port ram with one write port and one registered read port. */

`timescale 1ns/1ps

module ram_1r1w #(
	parameter int WIDTH       = 50,
	parameter int DEPTH_NBITS = 10
) (
	input  logic                   clk,
	input  logic                   we,
	input  logic [DEPTH_NBITS-1:0] waddr,
	input  logic [WIDTH-1:0]       wdata,
	input  logic [DEPTH_NBITS-1:0] raddr,
	output logic [WIDTH-1:0]       rdata
);

	// storage array, contents undefined until written.
	logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

	// write lands at the edge.
	// read samples the array before the write updates it,
	// so a same-address collision returns the old entry.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

	// the read port is clocked every cycle, so its address must always be known.
	// the write address only matters while we is high.
	// both come from the datapath address mux and the pio request.
	ram_addr_known: assert property (@(posedge clk)
		!$isunknown(raddr) && !$isunknown(we) && (!we || !$isunknown(waddr)))
		else $error("ram_1r1w address or write enable unknown");

endmodule

// File: hw/pio_ack_timer.sv
/* free-running divider that produces the slow pio bus tick. */

`timescale 1ns/1ps

module pio_ack_timer import pio_table_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	// modulo TICK_DIV count.
	logic [TICK_CNT_NBITS-1:0] cnt;

	// stands in for the divided bus clock enable.
	// runs whether or not there is pio traffic.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == TICK_LAST) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// one-cycle pulse in the last count of each period.
	assign tick = (cnt == TICK_LAST);

endmodule

// File: hw/pio_access_fsm.sv
/* pio access fsm. decodes pio requests into stage, commit, read low and
   read high, retries low reads around application reads, and paces the ack. */

`timescale 1ns/1ps

module pio_access_fsm import pio_table_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  pio_req_t pio_req,
	input  logic     tick,
	input  logic     port_busy,
	output pio_ctl_t pio_ctl,
	output logic     pio_ack
);

	typedef enum logic [2:0] {
		IDLE,
		RD_WAIT,
		RD_CAPTURE,
		ACK_SET,
		ACK_HOLD
	} state_t;

	state_t state;
	state_t state_nxt;

	// request for this module, and which dword half it targets.
	logic req_sel;
	logic req_hi;

	assign req_sel = pio_req.ms & (pio_req.rd | pio_req.wr);
	assign req_hi  = pio_req.addr[HALF_BIT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// strobes are decoded from the current state and, in IDLE, the live request.
	always_comb begin
		state_nxt = state;
		pio_ctl   = '0;
		case (state)
			IDLE: begin
				if (req_sel) begin
					if (pio_req.wr) begin
						// low half only stages, high half writes the whole entry.
						pio_ctl.stage_lo = ~req_hi;
						pio_ctl.commit   = req_hi;
						state_nxt        = ACK_SET;
					end else if (req_hi) begin
						// upper bits come from the holding register.
						pio_ctl.send_hi = 1'b1;
						state_nxt       = ACK_SET;
					end else begin
						// low read needs the ram read port.
						state_nxt = RD_WAIT;
					end
				end
			end
			RD_WAIT: begin
				// application reads own the port, retry until it is free.
				if (!port_busy) begin
					pio_ctl.rd_issue = 1'b1;
					state_nxt        = RD_CAPTURE;
				end
			end
			RD_CAPTURE: begin
				// ram output is valid one cycle after the issue.
				pio_ctl.capture = 1'b1;
				state_nxt       = ACK_SET;
			end
			ACK_SET: begin
				// first ack cycle, may already meet the tick.
				if (tick) begin
					state_nxt = IDLE;
				end else begin
					state_nxt = ACK_HOLD;
				end
			end
			ACK_HOLD: begin
				// hold ack for the slow bus until its next tick.
				if (tick) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	// ack is high in both ack states, straight from the state register.
	assign pio_ack = (state == ACK_SET) || (state == ACK_HOLD);

	// the master waits for the ack to rise and fall before its next request.
	fsm_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		req_sel |-> state == IDLE)
		else $error("pio request while the access fsm is busy");

	// a ram write and a pio ram read never share a cycle.
	fsm_commit_read_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(pio_ctl.commit && pio_ctl.rd_issue))
		else $error("commit and rd_issue high together");

endmodule

// File: hw/pio_wmem.sv
/* pio table datapath. staging and read holding registers, ram address mux,
   the fixed-latency application read pipeline and the table ram. */

`timescale 1ns/1ps

module pio_wmem import pio_table_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  pio_req_t             pio_req,
	input  pio_ctl_t             pio_ctl,
	input  app_rd_t              app_rd,
	output logic                 port_busy,
	output logic [PIO_NBITS-1:0] pio_rdata,
	output app_rsp_t             app_rsp
);

	// application pipeline.
	logic [DEPTH_NBITS-1:0] app_idx_q;
	logic                   app_v2;
	logic                   app_ack_q;
	logic [ENTRY_NBITS-1:0] app_data_q;

	// pio side.
	logic [DEPTH_NBITS-1:0] pio_idx;
	logic [DEPTH_NBITS-1:0] pio_idx_q;
	logic [PIO_NBITS-1:0]   lo_q;
	logic [HI_NBITS-1:0]    hi_q;

	// ram ports.
	logic [DEPTH_NBITS-1:0] ram_raddr;
	logic [ENTRY_NBITS-1:0] ram_wdata;
	logic [ENTRY_NBITS-1:0] ram_rdata;

	// table index from the byte address of the live request.
	assign pio_idx = pio_req.addr[IDX_LSB +: DEPTH_NBITS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			port_busy <= 1'b0;
			app_v2    <= 1'b0;
			app_ack_q <= 1'b0;
			pio_idx_q <= '0;
		end else begin
			// valid stage 1 is the cycle the app read owns the ram port.
			port_busy <= app_rd.rd;
			app_v2    <= port_busy;
			app_ack_q <= app_v2;
			// the request pulse is gone by the time a retried read issues.
			if (pio_req.ms && (pio_req.rd || pio_req.wr)) begin
				pio_idx_q <= pio_idx;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (app_rd.rd) begin
			app_idx_q <= app_rd.addr;
		end
		if (app_v2) begin
			app_data_q <= ram_rdata;
		end
		if (pio_ctl.stage_lo) begin
			lo_q <= pio_req.wdata;
		end
		// keep the upper bits for a later high read.
		if (pio_ctl.capture) begin
			hi_q <= ram_rdata[ENTRY_NBITS-1:PIO_NBITS];
		end
		if (pio_ctl.capture) begin
			pio_rdata <= ram_rdata[PIO_NBITS-1:0];
		end else if (pio_ctl.send_hi) begin
			// zero-extended upper half.
			pio_rdata <= PIO_NBITS'(hi_q);
		end
	end

	assign app_rsp.ack  = app_ack_q;
	assign app_rsp.data = app_data_q;

	// application reads always win the read port.
	assign ram_raddr = port_busy ? app_idx_q : pio_idx_q;

	// high dword write joins the staged low half.
	assign ram_wdata = {pio_req.wdata[HI_NBITS-1:0], lo_q};

	ram_1r1w #(
		.WIDTH      (ENTRY_NBITS),
		.DEPTH_NBITS(DEPTH_NBITS)
	) i_ram_1r1w (
		.clk  (clk),
		.we   (pio_ctl.commit),
		.waddr(pio_idx),
		.wdata(ram_wdata),
		.raddr(ram_raddr),
		.rdata(ram_rdata)
	);

	// every app read is answered exactly APP_RD_LAT cycles later, and only then.
	wmem_app_latency: assert property (@(posedge clk) disable iff (!rst_n)
		app_rsp.ack == $past(app_rd.rd, APP_RD_LAT))
		else $error("app_rsp.ack does not follow app_rd.rd by APP_RD_LAT");

endmodule

// File: hw/pio_table_top.sv
/* pio table top level. bus tick timer, access fsm and datapath. */

`timescale 1ns/1ps

module pio_table_top import pio_table_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  pio_req_t             pio_req,
	input  app_rd_t              app_rd,
	output logic                 pio_ack,
	output logic [PIO_NBITS-1:0] pio_rdata,
	output app_rsp_t             app_rsp
);

	// slow bus tick for the ack.
	logic     tick;
	// app read owns the ram read port this cycle.
	logic     port_busy;
	// strobes from the fsm into the datapath.
	pio_ctl_t pio_ctl;

	pio_ack_timer i_pio_ack_timer (
		.clk  (clk),
		.rst_n(rst_n),
		.tick (tick)
	);

	// sequences pio accesses and owns the ack.
	pio_access_fsm i_pio_access_fsm (
		.clk      (clk),
		.rst_n    (rst_n),
		.pio_req  (pio_req),
		.tick     (tick),
		.port_busy(port_busy),
		.pio_ctl  (pio_ctl),
		.pio_ack  (pio_ack)
	);

	// table ram with its pio and app data paths.
	pio_wmem i_pio_wmem (
		.clk      (clk),
		.rst_n    (rst_n),
		.pio_req  (pio_req),
		.pio_ctl  (pio_ctl),
		.app_rd   (app_rd),
		.port_busy(port_busy),
		.pio_rdata(pio_rdata),
		.app_rsp  (app_rsp)
	);

endmodule

// File: dv/tb_pio_table_model.svh
/* reference model of the pio table. committed entries, the staged low half,
   the held upper bits, and the functions that give expected app and pio data. */

`ifndef TB_PIO_TABLE_MODEL_SVH
`define TB_PIO_TABLE_MODEL_SVH

// table contents as committed by the pio master.
logic [ENTRY_NBITS-1:0] model_mem [2**DEPTH_NBITS];
// low half staged by the last low write.
logic [PIO_NBITS-1:0]   model_stage;
// upper bits kept by the last low read.
logic [HI_NBITS-1:0]    model_held;

// pio write. even dword stages, odd dword commits the whole entry.
function automatic void model_write(input logic [PIO_ADDR_NBITS-1:0] addr,
	input logic [PIO_NBITS-1:0] wdata);
	logic [DEPTH_NBITS-1:0] idx;
	idx = addr[DEPTH_NBITS+2:3];
	if (addr[2]) begin
		model_mem[idx] = {wdata[HI_NBITS-1:0], model_stage};
	end else begin
		model_stage = wdata;
	end
endfunction

// pio read. low read also keeps the upper bits for the next high read.
function automatic logic [PIO_NBITS-1:0] exp_pio_read(
	input logic [PIO_ADDR_NBITS-1:0] addr);
	logic [DEPTH_NBITS-1:0] idx;
	idx = addr[DEPTH_NBITS+2:3];
	if (addr[2]) begin
		// zero-extended upper half, no table access.
		return PIO_NBITS'(model_held);
	end
	model_held = model_mem[idx][ENTRY_NBITS-1:PIO_NBITS];
	return model_mem[idx][PIO_NBITS-1:0];
endfunction

// application lookup returns the whole entry.
function automatic logic [ENTRY_NBITS-1:0] exp_app_data(
	input logic [DEPTH_NBITS-1:0] idx);
	return model_mem[idx];
endfunction

`endif

// File: dv/tb_pio_table.sv
/* testbench for the pio table top level. clock, reset, pio and app stimulus,
   output compare process, check task and run timeout. */

`timescale 1ns/1ps

module tb_pio_table import pio_table_pkg::*; ();

	localparam int CYC_PER_OP     = 20;
	localparam int TIMEOUT_MARGIN = 100;

	logic                 clk = 1'b0;
	logic                 rst_n;
	pio_req_t             pio_req;
	app_rd_t              app_rd;
	logic                 pio_ack;
	logic [PIO_NBITS-1:0] pio_rdata;
	app_rsp_t             app_rsp;

	int                     seed = 32'h6022_502f;
	int unsigned            cyc = 0;
	int unsigned            ops_issued = 0;
	logic                   ack_q = 1'b0;
	logic [DEPTH_NBITS-1:0] written [$];
	// expected app responses and the cycle each one is due.
	int unsigned            app_due_q [$];
	logic [ENTRY_NBITS-1:0] app_exp_q [$];
	// expected pio completions in issue order.
	// data is only checked for reads.
	logic                   pio_rd_q [$];
	logic [PIO_NBITS-1:0]   pio_exp_q [$];

	`include "tb_pio_table_model.svh"

	pio_table_top i_pio_table_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.pio_req  (pio_req),
		.app_rd   (app_rd),
		.pio_ack  (pio_ack),
		.pio_rdata(pio_rdata),
		.app_rsp  (app_rsp)
	);

	always #50 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		if (exp !== act) begin
			fail_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
		end
	endtask

	// the limit grows with every operation issued.
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc > TIMEOUT_MARGIN + CYC_PER_OP * ops_issued) begin
			fail_run("run timed out waiting for the DUT");
		end
	end

	// outputs are sampled mid-cycle away from the driving edge.
	always @(negedge clk) begin : compare_outputs
		logic exp_ack;
		logic ack_rise;
		ack_rise = pio_ack && !ack_q;
		ack_q    = pio_ack;
		if (app_rd.rd) begin
			app_due_q.push_back(cyc + APP_RD_LAT);
			app_exp_q.push_back(exp_app_data(app_rd.addr));
		end
		exp_ack = (app_due_q.size() != 0) && (app_due_q[0] == cyc);
		check_value("app ack", exp_ack, app_rsp.ack);
		if (exp_ack) begin
			void'(app_due_q.pop_front());
			check_value("app data", app_exp_q.pop_front(), app_rsp.data);
		end
		if (ack_rise) begin
			if (pio_rd_q.size() == 0) begin
				fail_run("pio_ack rose with no pio access outstanding");
			end else if (pio_rd_q.pop_front()) begin
				check_value("pio rdata", pio_exp_q.pop_front(), pio_rdata);
			end else begin
				void'(pio_exp_q.pop_front());
			end
		end
	end

	function automatic logic [PIO_ADDR_NBITS-1:0] pio_addr(
		input logic [DEPTH_NBITS-1:0] idx, input logic hi);
		return PIO_ADDR_NBITS'({idx, hi, 2'b00});
	endfunction

	function automatic logic [DEPTH_NBITS-1:0] pick_written();
		logic [31:0] r;
		r = $random(seed);
		return written[r % written.size()];
	endfunction

	// one pio access that waits for the ack to rise and fall again.
	task automatic pio_access(input logic wr, input logic [DEPTH_NBITS-1:0] idx,
		input logic hi, input logic [PIO_NBITS-1:0] wdata);
		pio_req_t req;
		req.addr  = pio_addr(idx, hi);
		req.wdata = wdata;
		req.rd    = !wr;
		req.wr    = wr;
		req.ms    = 1'b1;
		@(posedge clk);
		pio_req <= req;
		ops_issued++;
		pio_rd_q.push_back(!wr);
		if (wr) begin
			model_write(req.addr, wdata);
			pio_exp_q.push_back('0);
		end else begin
			pio_exp_q.push_back(exp_pio_read(req.addr));
		end
		@(posedge clk);
		pio_req <= '0;
		do @(negedge clk); while (!pio_ack);
		do @(negedge clk); while (pio_ack);
	endtask

	task automatic write_entry(input logic [DEPTH_NBITS-1:0] idx);
		pio_access(1'b1, idx, 1'b0, $random(seed));
		pio_access(1'b1, idx, 1'b1, $random(seed));
		written.push_back(idx);
	endtask

	// app reads of random written entries at one per cycle.
	task automatic app_burst(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			app_rd <= {1'b1, pick_written()};
			ops_issued++;
		end
		@(posedge clk);
		app_rd <= '0;
		do @(negedge clk); while (app_due_q.size() != 0);
	endtask

	initial begin : run_tests
		logic [DEPTH_NBITS-1:0] idx;
		pio_req = '0;
		app_rd  = '0;
		rst_n   = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("reset pio_ack", 1'b0, pio_ack);
		check_value("reset app ack", 1'b0, app_rsp.ack);
		// full entries are committed and then read back through the app port.
		for (int i = 0; i < 8; i++) begin
			write_entry(DEPTH_NBITS'($random(seed)));
		end
		app_burst(8);
		// held upper bits survive a rewrite of the same and of another entry.
		idx = pick_written();
		pio_access(1'b0, idx, 1'b0, '0);
		write_entry(idx);
		write_entry(DEPTH_NBITS'($random(seed)));
		pio_access(1'b0, idx, 1'b1, '0);
		// a lone low write only stages and later high writes reuse it.
		idx = pick_written();
		pio_access(1'b1, idx, 1'b0, $random(seed));
		// the entry it addressed still reads back its old low half.
		pio_access(1'b0, idx, 1'b0, '0);
		app_burst(4);
		pio_access(1'b1, pick_written(), 1'b1, $random(seed));
		idx = DEPTH_NBITS'($random(seed));
		pio_access(1'b1, idx, 1'b1, $random(seed));
		written.push_back(idx);
		app_burst(30);
		// a pio low read retried behind a long app burst and then its high half.
		idx = pick_written();
		fork
			app_burst(40);
			begin
				repeat (4) @(posedge clk);
				pio_access(1'b0, idx, 1'b0, '0);
			end
		join
		pio_access(1'b0, idx, 1'b1, '0);
		repeat (4) @(negedge clk);
		if (app_due_q.size() != 0 || pio_rd_q.size() != 0) begin
			fail_run("expected responses still outstanding at the end of the run");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// File: filelist.f
+incdir+dv
hw/pio_table_pkg.sv
hw/ram_1r1w.sv
hw/pio_ack_timer.sv
hw/pio_access_fsm.sv
hw/pio_wmem.sv
hw/pio_table_top.sv
dv/tb_pio_table.sv

// File: Bender.yml
package:
  name: pio_table

sources:
  # design sources in compile order.
  - files:
      - hw/pio_table_pkg.sv
      - hw/ram_1r1w.sv
      - hw/pio_ack_timer.sv
      - hw/pio_access_fsm.sv
      - hw/pio_wmem.sv
      - hw/pio_table_top.sv

  # testbench, includes the reference model from dv.
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_pio_table.sv
